// ==== exu_alu.sv ====
// integer ALU
`timescale 1ns/1ps

module exu_alu
        import exu_pkg::*;
(
        input  exu_stage_t stage_i,
        output xlen_t      alu_result_o,
        output exu_cmp_t   cmp_o
);

        logic [2:0] funct3;
        logic [4:0] opcode;
        logic       sub_sel;
        logic       sra_sel;
        logic [4:0] shamt;
        xlen_t      x;
        xlen_t      y;
        exu_cmp_t   cmp;
        xlen_t      result;

        assign x      = stage_i.x;
        assign y      = stage_i.y;
        assign funct3 = stage_i.instr.r.funct3;
        assign opcode = stage_i.instr.r.opcode[6:2];
        assign shamt  = y[4:0];

        // bit 30 picks sub only for the register class, addi never subtracts
        assign sub_sel = (opcode == OPC_OP) && stage_i.instr.r.funct7[5];
        assign sra_sel = stage_i.instr.r.funct7[5];

        // ----------------------------------------
        // comparisons, shared with branches
        // ----------------------------------------
        assign cmp.eq  = (x == y);
        assign cmp.lt  = ($signed(x) < $signed(y));
        assign cmp.ltu = (x < y);

        // ----------------------------------------
        // operation select
        // ----------------------------------------
        always_comb begin
                case (funct3)
                        ALU_ADD_SUB: result = sub_sel ? (x - y) : (x + y);
                        ALU_SLL:     result = x << shamt;
                        ALU_SLT:     result = {31'd0, cmp.lt};
                        ALU_SLTU:    result = {31'd0, cmp.ltu};
                        ALU_XOR:     result = x ^ y;
                        ALU_SRL_SRA: begin
                                if (sra_sel) begin
                                        result = $signed(x) >>> shamt;
                                end else begin
                                        result = x >> shamt;
                                end
                        end
                        ALU_OR:      result = x | y;
                        default:     result = x & y;
                endcase
        end

        assign alu_result_o = result;
        assign cmp_o        = cmp;

endmodule

// ==== exu_branch_unit.sv ====
// branch and jump redirect
`timescale 1ns/1ps

module exu_branch_unit
        import exu_pkg::*;
(
        input  exu_stage_t    stage_i,
        input  exu_cmp_t      cmp_i,
        output exu_redirect_t redirect_o
);

        logic  cond;
        xlen_t i_imm;
        pc_t   jalr_target;

        // ----------------------------------------
        // branch condition
        // ----------------------------------------
        always_comb begin
                case (stage_i.instr.b.funct3)
                        BR_BEQ:  cond = cmp_i.eq;
                        BR_BNE:  cond = ~cmp_i.eq;
                        BR_BLT:  cond = cmp_i.lt;
                        BR_BGE:  cond = ~cmp_i.lt;
                        BR_BLTU: cond = cmp_i.ltu;
                        BR_BGEU: cond = ~cmp_i.ltu;
                        // reserved encodings never branch
                        default: cond = 1'b0;
                endcase
        end

        // ----------------------------------------
        // target
        // ----------------------------------------
        assign i_imm = {{20{stage_i.instr.i.imm_11_0[11]}}, stage_i.instr.i.imm_11_0};

        // jalr clears bit 0 of the sum
        assign jalr_target = (stage_i.x + i_imm) & ~32'd1;

        assign redirect_o.taken = (stage_i.ctl.branch & cond) |
                                  stage_i.ctl.jal | stage_i.ctl.jalr;

        always_comb begin
                if (stage_i.ctl.jalr) begin
                        redirect_o.target = jalr_target;
                end else if (stage_i.ctl.jal) begin
                        redirect_o.target = stage_i.jal_target;
                end else begin
                        redirect_o.target = stage_i.branch_target;
                end
        end

endmodule

// ==== exu_operand_stage.sv ====
// execution operand stage
`timescale 1ns/1ps

module exu_operand_stage
        import exu_pkg::*;
(
        input  logic       clk,
        input  logic       reset_n,

        // strobe from the controller
        input  logic       exe_enable_i,

        // decoded instruction
        input  instr_t     instr_i,
        input  pc_t        pc_i,
        input  exu_ctl_t   ctl_i,

        // register file operands
        input  xlen_t      rs1_i,
        input  xlen_t      rs2_i,

        output exu_stage_t stage_o,
        output logic       valid_o
);

        xlen_t      i_imm;
        xlen_t      b_imm;
        xlen_t      u_imm;
        xlen_t      j_imm;
        pc_t        pc_step;
        exu_stage_t stage_d;
        exu_stage_t stage_q;
        logic       valid_q;

        // ----------------------------------------
        // immediates
        // ----------------------------------------
        assign i_imm = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};

        assign b_imm = {{20{instr_i.b.imm_12}}, instr_i.b.imm_11,
                        instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};

        assign u_imm = {instr_i.u.imm_31_12, 12'd0};

        assign j_imm = {{12{instr_i.j.imm_20}}, instr_i.j.imm_19_12,
                        instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};

        // compressed instructions link to pc + 2
        assign pc_step = ctl_i.is_compressed ? PC_STEP_COMP : PC_STEP_FULL;

        // ----------------------------------------
        // next stage contents
        // ----------------------------------------
        always_comb begin
                stage_d.instr         = instr_i;
                stage_d.pc            = pc_i;
                stage_d.ctl           = ctl_i;
                stage_d.x             = rs1_i;
                stage_d.y             = ctl_i.load_y_from_imm ? i_imm : rs2_i;
                stage_d.u_imm         = u_imm;
                stage_d.auipc_sum     = pc_i + u_imm;
                stage_d.branch_target = pc_i + b_imm;
                stage_d.jal_target    = pc_i + j_imm;
                stage_d.link_value    = pc_i + pc_step;
        end

        // ----------------------------------------
        // stage register
        // ----------------------------------------
        always_ff @(posedge clk or negedge reset_n) begin
                if (!reset_n) begin
                        stage_q <= '0;
                        valid_q <= 1'b0;
                end else begin
                        valid_q <= exe_enable_i;
                        if (exe_enable_i) begin
                                stage_q <= stage_d;
                        end else begin
                                // idle cycle, no write-back and no redirect
                                stage_q.ctl <= '0;
                        end
                end
        end

        assign stage_o = stage_q;
        assign valid_o = valid_q;

endmodule

// ==== exu_pkg.sv ====
// execution stage shared definitions
package exu_pkg;

        // ----------------------------------------
        // widths and basic types
        // ----------------------------------------
        localparam int XLEN          = 32;
        localparam int REG_ADDR_BITS = 5;

        typedef logic [XLEN-1:0]          xlen_t;
        typedef logic [XLEN-1:0]          pc_t;
        typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;

        // alu funct3 codes
        localparam logic [2:0] ALU_ADD_SUB = 3'b000;
        localparam logic [2:0] ALU_SLL     = 3'b001;
        localparam logic [2:0] ALU_SLT     = 3'b010;
        localparam logic [2:0] ALU_SLTU    = 3'b011;
        localparam logic [2:0] ALU_XOR     = 3'b100;
        localparam logic [2:0] ALU_SRL_SRA = 3'b101;
        localparam logic [2:0] ALU_OR      = 3'b110;
        localparam logic [2:0] ALU_AND     = 3'b111;

        // branch funct3 codes
        localparam logic [2:0] BR_BEQ  = 3'b000;
        localparam logic [2:0] BR_BNE  = 3'b001;
        localparam logic [2:0] BR_BLT  = 3'b100;
        localparam logic [2:0] BR_BGE  = 3'b101;
        localparam logic [2:0] BR_BLTU = 3'b110;
        localparam logic [2:0] BR_BGEU = 3'b111;

        // opcode bits [6:2], the low two bits are always 2'b11
        localparam logic [4:0] OPC_OP     = 5'b01100;
        localparam logic [4:0] OPC_OP_IMM = 5'b00100;

        // link offsets
        localparam pc_t PC_STEP_FULL = 32'd4;
        localparam pc_t PC_STEP_COMP = 32'd2;

        // ----------------------------------------
        // instruction formats
        // ----------------------------------------
        typedef struct packed {
                logic [6:0] funct7;
                reg_addr_t  rs2;
                reg_addr_t  rs1;
                logic [2:0] funct3;
                reg_addr_t  rd;
                logic [6:0] opcode;
        } r_fmt_t;

        typedef struct packed {
                logic [11:0] imm_11_0;
                reg_addr_t   rs1;
                logic [2:0]  funct3;
                reg_addr_t   rd;
                logic [6:0]  opcode;
        } i_fmt_t;

        typedef struct packed {
                logic       imm_12;
                logic [5:0] imm_10_5;
                reg_addr_t  rs2;
                reg_addr_t  rs1;
                logic [2:0] funct3;
                logic [3:0] imm_4_1;
                logic       imm_11;
                logic [6:0] opcode;
        } b_fmt_t;

        typedef struct packed {
                logic [19:0] imm_31_12;
                reg_addr_t   rd;
                logic [6:0]  opcode;
        } u_fmt_t;

        typedef struct packed {
                logic       imm_20;
                logic [9:0] imm_10_1;
                logic       imm_11;
                logic [7:0] imm_19_12;
                reg_addr_t  rd;
                logic [6:0] opcode;
        } j_fmt_t;

        // one word, read through whichever format applies
        typedef union packed {
                r_fmt_t r;
                i_fmt_t i;
                b_fmt_t b;
                u_fmt_t u;
                j_fmt_t j;
        } instr_t;

        // ----------------------------------------
        // port records
        // ----------------------------------------
        typedef struct packed {
                logic load_y_from_imm;
                logic save_to_rd;
                logic lui;
                logic auipc;
                logic jal;
                logic jalr;
                logic branch;
                logic is_compressed;
        } exu_ctl_t;

        typedef struct packed {
                logic eq;
                logic lt;
                logic ltu;
        } exu_cmp_t;

        typedef struct packed {
                reg_addr_t rd_addr;
                logic      save_to_rd;
                xlen_t     data;
        } exu_wb_t;

        typedef struct packed {
                logic taken;
                pc_t  target;
        } exu_redirect_t;

        // registered stage contents
        typedef struct packed {
                instr_t   instr;
                pc_t      pc;
                exu_ctl_t ctl;
                xlen_t    x;
                xlen_t    y;
                xlen_t    u_imm;
                xlen_t    auipc_sum;
                pc_t      branch_target;
                pc_t      jal_target;
                pc_t      link_value;
        } exu_stage_t;

endpackage

// ==== exu_result_select.sv ====
// write-back value select
`timescale 1ns/1ps

module exu_result_select
        import exu_pkg::*;
(
        input  exu_stage_t stage_i,
        input  xlen_t      alu_result_i,
        output exu_wb_t    wb_o
);

        xlen_t data;

        // ----------------------------------------
        // data priority
        // ----------------------------------------
        always_comb begin
                if (stage_i.ctl.lui) begin
                        data = stage_i.u_imm;
                end else if (stage_i.ctl.auipc) begin
                        data = stage_i.auipc_sum;
                end else if (stage_i.ctl.jal || stage_i.ctl.jalr) begin
                        // return address, pc + 2 or pc + 4
                        data = stage_i.link_value;
                end else begin
                        data = alu_result_i;
                end
        end

        assign wb_o.rd_addr    = stage_i.instr.r.rd;
        assign wb_o.save_to_rd = stage_i.ctl.save_to_rd;
        assign wb_o.data       = data;

endmodule

// ==== exu_sva.sv ====
// execution stage strobe assertions
`timescale 1ns/1ps

module exu_sva
        import exu_pkg::*;
(
        input logic          clk,
        input logic          reset_n,
        input logic          exe_enable_i,
        input logic          valid_i,
        input exu_wb_t       wb_i,
        input exu_redirect_t redirect_i
);

        // result strobe trails the enable by one edge
        valid_follows_enable: assert property (
                @(posedge clk) disable iff (!reset_n)
                valid_i == $past(exe_enable_i)
        ) else $error("valid_o does not follow the enable of the previous edge");

        taken_needs_valid: assert property (
                @(posedge clk) disable iff (!reset_n)
                redirect_i.taken |-> valid_i
        ) else $error("redirect taken without a valid result");

        write_needs_valid: assert property (
                @(posedge clk) disable iff (!reset_n)
                wb_i.save_to_rd |-> valid_i
        ) else $error("register write without a valid result");

endmodule

// ==== exu_top.sv ====
// integer execution stage top
`timescale 1ns/1ps

module exu_top
        import exu_pkg::*;
(
        input  logic          clk,
        input  logic          reset_n,

        input  logic          exe_enable_i,
        input  instr_t        instr_i,
        input  pc_t           pc_i,
        input  exu_ctl_t      ctl_i,
        input  xlen_t         rs1_i,
        input  xlen_t         rs2_i,

        // one cycle after the enable
        output logic          valid_o,
        output exu_wb_t       wb_o,
        output exu_redirect_t redirect_o
);

        exu_stage_t stage;
        xlen_t      alu_result;
        exu_cmp_t   cmp;

        exu_operand_stage u_operand_stage (
                .clk          (clk),
                .reset_n      (reset_n),
                .exe_enable_i (exe_enable_i),
                .instr_i      (instr_i),
                .pc_i         (pc_i),
                .ctl_i        (ctl_i),
                .rs1_i        (rs1_i),
                .rs2_i        (rs2_i),
                .stage_o      (stage),
                .valid_o      (valid_o)
        );

        exu_alu u_alu (
                .stage_i      (stage),
                .alu_result_o (alu_result),
                .cmp_o        (cmp)
        );

        exu_branch_unit u_branch_unit (
                .stage_i    (stage),
                .cmp_i      (cmp),
                .redirect_o (redirect_o)
        );

        exu_result_select u_result_select (
                .stage_i      (stage),
                .alu_result_i (alu_result),
                .wb_o         (wb_o)
        );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execution stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_exu -f vlog.f -o tb_exu_sim

# the log decides pass or fail
./obj_dir/tb_exu_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

grep -q "TESTBENCH PASSED" sim.log

// ==== tb_exu_model.svh ====
// execution stage reference model

logic [31:0] rng_state = 32'h0997_e401;

// lcg step, halves swapped so small fields get the better bits
function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {rng_state[15:0], rng_state[31:16]};
endfunction

function automatic xlen_t model_alu(logic [31:0] w, xlen_t a, xlen_t b);
        logic [4:0] sh;
        xlen_t      fill;
        sh   = b[4:0];
        // sign bits shifted in for sra
        fill = (w[30] && a[31]) ? ~(32'hffff_ffff >> sh) : 32'd0;
        case (w[14:12])
                ALU_ADD_SUB: return (w[30] && (w[6:2] == OPC_OP)) ? a - b : a + b;
                ALU_SLL:     return a << sh;
                ALU_SLT:     return {31'd0, $signed(a) < $signed(b)};
                ALU_SLTU:    return {31'd0, a < b};
                ALU_XOR:     return a ^ b;
                ALU_SRL_SRA: return (a >> sh) | fill;
                ALU_OR:      return a | b;
                default:     return a & b;
        endcase
endfunction

function automatic exu_wb_t model_wb(logic [31:0] w, pc_t pc, exu_ctl_t ctl,
                                     xlen_t rs1, xlen_t rs2);
        exu_wb_t wb;
        xlen_t   y;
        y             = ctl.load_y_from_imm ? {{20{w[31]}}, w[31:20]} : rs2;
        wb.rd_addr    = w[11:7];
        wb.save_to_rd = ctl.save_to_rd;
        if (ctl.lui) begin
                wb.data = {w[31:12], 12'h000};
        end else if (ctl.auipc) begin
                wb.data = pc + {w[31:12], 12'h000};
        end else if (ctl.jal || ctl.jalr) begin
                wb.data = pc + (ctl.is_compressed ? 32'd2 : 32'd4);
        end else begin
                wb.data = model_alu(w, rs1, y);
        end
        return wb;
endfunction

function automatic exu_redirect_t model_redirect(logic [31:0] w, pc_t pc, exu_ctl_t ctl,
                                                 xlen_t rs1, xlen_t rs2);
        exu_redirect_t redir;
        logic          cond;
        case (w[14:12])
                3'b000:  cond = (rs1 == rs2);
                3'b001:  cond = (rs1 != rs2);
                3'b100:  cond = ($signed(rs1) < $signed(rs2));
                3'b101:  cond = ($signed(rs1) >= $signed(rs2));
                3'b110:  cond = (rs1 < rs2);
                3'b111:  cond = (rs1 >= rs2);
                default: cond = 1'b0;
        endcase
        redir.taken = (ctl.branch && cond) || ctl.jal || ctl.jalr;
        if (ctl.jalr) begin
                redir.target = (rs1 + {{20{w[31]}}, w[31:20]}) & 32'hffff_fffe;
        end else if (ctl.jal) begin
                redir.target = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end else begin
                redir.target = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
        return redir;
endfunction

// ==== tb_exu.sv ====
// execution stage testbench
`timescale 1ns/1ps

module tb_exu
        import exu_pkg::*;
();

        localparam int RESET_CYCLES = 8;
        localparam int TEST_CYCLES  = 300;
        localparam int NUM_TESTS    = 6;
        localparam int IDLE_TEST    = 5;
        localparam int CYCLE_LIMIT  = (RESET_CYCLES + NUM_TESTS * TEST_CYCLES) * 3 / 2;

        typedef struct packed {
                int            test_id;
                int            due_cycle;
                exu_wb_t       wb;
                exu_redirect_t redirect;
        } expect_t;

        logic          clk = 1'b0;
        logic          reset_n;
        logic          exe_enable_i;
        instr_t        instr_i;
        pc_t           pc_i;
        exu_ctl_t      ctl_i;
        xlen_t         rs1_i;
        xlen_t         rs2_i;
        logic          valid_o;
        exu_wb_t       wb_o;
        exu_redirect_t redirect_o;

        expect_t       exp_q[$];
        int            cycle_count = 0;
        // reset checks count toward the idle test
        int            cur_test = IDLE_TEST;
        int            err_count[NUM_TESTS];
        int            chk_count[NUM_TESTS];
        string         test_name[NUM_TESTS] = '{"alu_rr", "alu_imm", "upper_imm",
                                                "branch", "jump", "idle"};

        `include "tb_exu_model.svh"

        always #4 clk = ~clk;

        exu_top u_dut (.*);

        bind exu_top exu_sva u_sva (
                .clk          (clk),
                .reset_n      (reset_n),
                .exe_enable_i (exe_enable_i),
                .valid_i      (valid_o),
                .wb_i         (wb_o),
                .redirect_i   (redirect_o)
        );

        // ----------------------------------------
        // compare tasks
        // ----------------------------------------
        task automatic check_wb(input int id, input exu_wb_t exp, input exu_wb_t act);
                if (act !== exp) begin
                        $display("ERR %s: wb exp rd=%0d we=%b data=%h got rd=%0d we=%b data=%h",
                                 test_name[id], exp.rd_addr, exp.save_to_rd, exp.data,
                                 act.rd_addr, act.save_to_rd, act.data);
                        err_count[id]++;
                end
        endtask

        task automatic check_redirect(input int id, input exu_redirect_t exp,
                                      input exu_redirect_t act);
                if (act !== exp) begin
                        $display("ERR %s: redirect exp taken=%b target=%h got taken=%b target=%h",
                                 test_name[id], exp.taken, exp.target, act.taken, act.target);
                        err_count[id]++;
                end
        endtask

        // ----------------------------------------
        // stimulus for one instruction class
        // ----------------------------------------
        task automatic make_stimulus(input int kind, output logic [31:0] w,
                                     output exu_ctl_t ctl);
                logic [31:0] r;
                logic [2:0]  f3;
                logic        alt;
                r   = next_random();
                w   = next_random();
                ctl = '0;
                ctl.is_compressed = r[0];
                case (kind)
                        0: begin
                                f3       = w[14:12];
                                alt      = r[1] && (f3 == 3'b000 || f3 == 3'b101);
                                w[6:0]   = 7'b0110011;
                                w[31:25] = alt ? 7'h20 : 7'h00;
                                ctl.save_to_rd = 1'b1;
                        end
                        1: begin
                                w[6:0] = 7'b0010011;
                                // slli, srli and srai keep a shamt form
                                if (w[13:12] == 2'b01) begin
                                        w[31:25] = {1'b0, r[1] & w[14], 5'b0};
                                end
                                ctl.load_y_from_imm = 1'b1;
                                ctl.save_to_rd      = 1'b1;
                        end
                        2: begin
                                w[6:0]         = r[1] ? 7'b0110111 : 7'b0010111;
                                ctl.lui        = r[1];
                                ctl.auipc      = ~r[1];
                                ctl.save_to_rd = 1'b1;
                        end
                        3: begin
                                // map three random bits onto the six branch codes
                                f3 = r[4:2];
                                if (f3 > 3'd5) begin
                                        f3 = f3 - 3'd6;
                                end
                                if (f3 > 3'd1) begin
                                        f3 = f3 + 3'd2;
                                end
                                w[6:0]     = 7'b1100011;
                                w[14:12]   = f3;
                                ctl.branch = 1'b1;
                        end
                        4: begin
                                w[6:0]              = r[1] ? 7'b1101111 : 7'b1100111;
                                ctl.jal             = r[1];
                                ctl.jalr            = ~r[1];
                                ctl.load_y_from_imm = ~r[1];
                                ctl.save_to_rd      = 1'b1;
                                if (!r[1]) begin
                                        w[14:12] = 3'b000;
                                end
                        end
                        default: ctl = r[15:8];
                endcase
        endtask

        // ----------------------------------------
        // cycle counter and timeout
        // ----------------------------------------
        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= CYCLE_LIMIT) begin
                        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
                        $display("TESTBENCH FAILED");
                        $finish;
                end
        end

        // outputs are stable at the falling edge
        always @(negedge clk) begin
                expect_t e;
                if (exp_q.size() != 0 && exp_q[0].due_cycle == cycle_count) begin
                        e = exp_q.pop_front();
                        chk_count[e.test_id]++;
                        if (!valid_o) begin
                                $display("test %s: valid_o stayed low when a result was due",
                                         test_name[e.test_id]);
                                err_count[e.test_id]++;
                        end
                        check_wb(e.test_id, e.wb, wb_o);
                        check_redirect(e.test_id, e.redirect, redirect_o);
                end else begin
                        chk_count[cur_test]++;
                        if (valid_o || redirect_o.taken || wb_o.save_to_rd) begin
                                $display("test %s: valid, taken or write high in an idle cycle",
                                         test_name[cur_test]);
                                err_count[cur_test]++;
                        end
                end
        end

        // ----------------------------------------
        // main sequence
        // ----------------------------------------
        initial begin
                logic [31:0] w;
                logic [31:0] r;
                exu_ctl_t    ctl;
                xlen_t       a;
                xlen_t       b;
                pc_t         pc;
                logic        en;
                expect_t     e;
                int          passed;
                int          failed;
                passed       = 0;
                failed       = 0;
                reset_n      = 1'b0;
                exe_enable_i = 1'b0;
                instr_i      = '0;
                pc_i         = '0;
                ctl_i        = '0;
                rs1_i        = '0;
                rs2_i        = '0;
                repeat (RESET_CYCLES) @(posedge clk);
                reset_n <= 1'b1;
                for (int t = 0; t < NUM_TESTS; t++) begin
                        cur_test = t;
                        for (int n = 0; n < TEST_CYCLES; n++) begin
                                @(posedge clk);
                                make_stimulus(t, w, ctl);
                                r  = next_random();
                                a  = next_random();
                                b  = (r[5:4] == 2'b00) ? a : next_random();
                                pc = next_random() & 32'hffff_fffe;
                                en = (t != IDLE_TEST) && (r[9:8] != 2'b00);
                                exe_enable_i <= en;
                                instr_i      <= w;
                                pc_i         <= pc;
                                ctl_i        <= ctl;
                                rs1_i        <= a;
                                rs2_i        <= b;
                                if (en) begin
                                        e.test_id   = t;
                                        e.due_cycle = cycle_count + 2;
                                        e.wb        = model_wb(w, pc, ctl, a, b);
                                        e.redirect  = model_redirect(w, pc, ctl, a, b);
                                        exp_q.push_back(e);
                                end
                        end
                        @(posedge clk);
                        exe_enable_i <= 1'b0;
                        while (exp_q.size() != 0) @(posedge clk);
                        $display("test %s: %0d checks, %0d errors",
                                 test_name[t], chk_count[t], err_count[t]);
                        if (err_count[t] == 0) begin
                                passed++;
                        end else begin
                                failed++;
                        end
                end
                $display("tests passed %0d, tests failed %0d", passed, failed);
                if (failed == 0) begin
                        $display("TESTBENCH PASSED");
                end else begin
                        $display("TESTBENCH FAILED");
                end
                $finish;
        end

endmodule

// ==== vlog.f ====
+incdir+.
exu_pkg.sv
exu_alu.sv
exu_branch_unit.sv
exu_result_select.sv
exu_operand_stage.sv
exu_top.sv
exu_sva.sv
tb_exu.sv
